// ==== rtl/bpredPkg.sv ====
// Shared sizes, class codes and stage bundles for the branch predictor
// Fixed 32-bit addresses, no compressed instructions, table sizes are powers of two
package bpredPkg;

  ////////////////////
  // Sizes
  ////////////////////
  localparam int xLen         = 32;
  localparam int dirIndexBits = 6;   // 64 direction counters
  localparam int btbIndexBits = 4;   // 16 BTB entries
  localparam int rasDepth     = 4;

  ////////////////////
  // Encodings
  ////////////////////
  typedef enum logic [2:0] {
    clsNone   = 3'd0,
    clsBranch = 3'd1,
    clsJump   = 3'd2,
    clsReturn = 3'd3,
    clsCall   = 3'd4
  } instrClassT;

  // RISC-V major opcodes of control-flow instructions
  typedef enum logic [6:0] {
    opBranch = 7'b1100011,
    opJalr   = 7'b1100111,
    opJal    = 7'b1101111
  } opcodeT;

  ////////////////////
  // Stage bundles
  ////////////////////
  typedef struct packed {logic valid; logic [xLen-1:0] pc;} fetchT;
  typedef struct packed {logic valid; logic [xLen-1:0] pc; logic [31:0] instr;} decodeT;
  typedef struct packed {logic valid; logic taken; logic [xLen-1:0] target;} resolveT;
  // Target is the BTB target, or the RAS top for a return
  typedef struct packed {instrClassT cls; logic taken; logic [xLen-1:0] target;} predictT;
  typedef struct packed {logic wrong; logic [xLen-1:0] pc;} correctT;
  typedef struct packed {
    logic dirWrong;
    logic targetWrong;
    logic rasWrong;
    logic classWrong;
  } missT;

endpackage

// ==== rtl/twoBitPredictor.sv ====
// Table of two-bit saturating counters indexed by PC word bits, no tag
// Aliasing branches share a counter
`timescale 1ns/100ps

module twoBitPredictor (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic [bpredPkg::xLen-1:0]  pcF,
  output logic                       dirTakenF,
  input  logic                       updValid,
  input  bpredPkg::instrClassT       updClass,
  input  logic [bpredPkg::xLen-1:0]  updPc,
  input  logic                       taken
);

  logic [1:0]                        ctrTable [2**bpredPkg::dirIndexBits];
  logic [bpredPkg::dirIndexBits-1:0] rdIdx;
  logic [bpredPkg::dirIndexBits-1:0] wrIdx;
  logic                              wrEn;

  // Word index, low two bits always zero
  assign rdIdx = pcF[bpredPkg::dirIndexBits+1:2];
  assign wrIdx = updPc[bpredPkg::dirIndexBits+1:2];

  // Upper bit is the taken prediction
  assign dirTakenF = ctrTable[rdIdx][1];

  // Only resolved branches train the counters
  assign wrEn = updValid && (updClass == bpredPkg::clsBranch);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      // Weakly not taken
      for (int i = 0; i < 2**bpredPkg::dirIndexBits; i++) ctrTable[i] <= 2'b01;
    end else if (wrEn) begin
      if (taken && (ctrTable[wrIdx] != 2'b11)) begin
        ctrTable[wrIdx] <= ctrTable[wrIdx] + 2'b01;
      end else if (!taken && (ctrTable[wrIdx] != 2'b00)) begin
        ctrTable[wrIdx] <= ctrTable[wrIdx] - 2'b01;
      end
    end
  end

endmodule

// ==== rtl/btb.sv ====
// Direct-mapped BTB, a new write replaces whatever shared the index
// Only taken control-flow instructions are allocated
`timescale 1ns/100ps

module btb (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic [bpredPkg::xLen-1:0]  pcF,
  output logic                       btbHit,
  output bpredPkg::instrClassT       btbClass,
  output logic [bpredPkg::xLen-1:0]  btbTarget,
  input  logic                       updValid,
  input  bpredPkg::instrClassT       updClass,
  input  logic [bpredPkg::xLen-1:0]  updPc,
  input  logic                       taken,
  input  logic [bpredPkg::xLen-1:0]  target
);

  logic [2**bpredPkg::btbIndexBits-1:0]              validMem;
  logic [bpredPkg::xLen-1:bpredPkg::btbIndexBits+2]  tagMem    [2**bpredPkg::btbIndexBits];
  bpredPkg::instrClassT                              classMem  [2**bpredPkg::btbIndexBits];
  logic [bpredPkg::xLen-1:0]                         targetMem [2**bpredPkg::btbIndexBits];
  logic [bpredPkg::btbIndexBits-1:0]                 rdIdx;
  logic [bpredPkg::btbIndexBits-1:0]                 wrIdx;
  logic                                              wrEn;

  assign rdIdx = pcF[bpredPkg::btbIndexBits+1:2];
  assign wrIdx = updPc[bpredPkg::btbIndexBits+1:2];

  // Hit needs a valid entry and matching upper PC bits
  assign btbHit    = validMem[rdIdx] &&
                     (tagMem[rdIdx] == pcF[bpredPkg::xLen-1:bpredPkg::btbIndexBits+2]);
  assign btbClass  = classMem[rdIdx];
  assign btbTarget = targetMem[rdIdx];

  assign wrEn = updValid && taken && (updClass != bpredPkg::clsNone);

  // Valid bits
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validMem <= '0;
    end else if (wrEn) begin
      validMem[wrIdx] <= 1'b1;
    end
  end

  // Entry payload, meaningless until valid
  always_ff @(posedge clk) begin
    if (wrEn) begin
      tagMem[wrIdx]    <= updPc[bpredPkg::xLen-1:bpredPkg::btbIndexBits+2];
      classMem[wrIdx]  <= updClass;
      targetMem[wrIdx] <= target;
    end
  end

endmodule

// ==== rtl/returnStack.sv ====
// Circular RAS, depth must be a power of two so the pointer wraps by itself
// Updated at execute only, no repair of wrong-path pushes or pops
`timescale 1ns/100ps

module returnStack (
  input  logic                       clk,
  input  logic                       rstN,
  output logic [bpredPkg::xLen-1:0]  rasTop,
  input  logic                       updValid,
  input  bpredPkg::instrClassT       updClass,
  input  logic [bpredPkg::xLen-1:0]  updPc
);

  logic [bpredPkg::xLen-1:0]              stack [bpredPkg::rasDepth];
  logic [$clog2(bpredPkg::rasDepth)-1:0]  ptr;
  logic [$clog2(bpredPkg::rasDepth)-1:0]  ptrInc;
  logic                                   push;
  logic                                   pop;

  assign push   = updValid && (updClass == bpredPkg::clsCall);
  assign pop    = updValid && (updClass == bpredPkg::clsReturn);
  assign ptrInc = ptr + 1'b1;

  // Pointer addresses the most recent link
  assign rasTop = stack[ptr];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ptr <= '0;
      for (int i = 0; i < bpredPkg::rasDepth; i++) stack[i] <= '0;
    end else if (push) begin
      // Full stack drops its oldest link here
      stack[ptrInc] <= updPc + bpredPkg::xLen'(4);
      ptr           <= ptrInc;
    end else if (pop) begin
      ptr <= ptr - 1'b1;
    end
  end

endmodule

// ==== rtl/instrClassDecode.sv ====
// Class decode of the decode-stage instruction, carried into execute
// Calls are jal with link rd only, jalr with a link rd decodes as a jump
`timescale 1ns/100ps

module instrClassDecode (
  input  logic                       clk,
  input  logic                       rstN,
  input  bpredPkg::decodeT           decode,
  output bpredPkg::instrClassT       classD,
  output bpredPkg::instrClassT       classE,
  output logic [bpredPkg::xLen-1:0]  pcE,
  output logic                       validE
);

  logic [4:0] rd;
  logic [4:0] rs1;
  logic       rdLink;
  logic       rs1Link;

  assign rd  = decode.instr[11:7];
  assign rs1 = decode.instr[19:15];

  // x1 and x5 are the link registers
  assign rdLink  = (rd == 5'd1) || (rd == 5'd5);
  assign rs1Link = (rs1 == 5'd1) || (rs1 == 5'd5);

  always_comb begin
    classD = bpredPkg::clsNone;
    if (decode.valid) begin
      case (bpredPkg::opcodeT'(decode.instr[6:0]))
        bpredPkg::opBranch: classD = bpredPkg::clsBranch;
        bpredPkg::opJal:    classD = rdLink ? bpredPkg::clsCall : bpredPkg::clsJump;
        // Return only with no link written
        bpredPkg::opJalr:   classD = (rs1Link && (rd == 5'd0)) ? bpredPkg::clsReturn
                                                               : bpredPkg::clsJump;
        default:            classD = bpredPkg::clsNone;
      endcase
    end
  end

  // D to E stage register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      classE <= bpredPkg::clsNone;
      pcE    <= '0;
      validE <= 1'b0;
    end else begin
      classE <= classD;
      pcE    <= decode.pc;
      validE <= decode.valid;
    end
  end

endmodule

// ==== rtl/bpredResolve.sv ====
// Next-PC choice at fetch, prediction check at execute, miss reasons one cycle later
// No stalls or flushes, every stage register advances each cycle
`timescale 1ns/100ps

module bpredResolve (
  input  logic                       clk,
  input  logic                       rstN,
  input  bpredPkg::fetchT            fetch,
  input  bpredPkg::decodeT           decode,
  input  bpredPkg::resolveT          resolve,
  input  logic                       btbHit,
  input  bpredPkg::instrClassT       btbClass,
  input  logic [bpredPkg::xLen-1:0]  btbTarget,
  input  logic                       dirTakenF,
  input  logic [bpredPkg::xLen-1:0]  rasTop,
  input  bpredPkg::instrClassT       classE,
  input  logic [bpredPkg::xLen-1:0]  pcE,
  input  logic                       validE,
  output logic [bpredPkg::xLen-1:0]  pcNext,
  output bpredPkg::correctT          correct,
  output bpredPkg::missT             miss,
  output logic                       updValid,
  output bpredPkg::instrClassT       updClass,
  output logic [bpredPkg::xLen-1:0]  updPc
);

  bpredPkg::predictT          predF;
  bpredPkg::predictT          predD;
  bpredPkg::predictT          predE;
  bpredPkg::missT             missE;
  logic [bpredPkg::xLen-1:0]  pcPlus4F;
  logic [bpredPkg::xLen-1:0]  predPcF;
  logic [bpredPkg::xLen-1:0]  pcCorrectE;
  logic                       eValid;
  logic                       cfiE;

  ////////////////////
  // Fetch prediction
  ////////////////////
  assign pcPlus4F = fetch.pc + bpredPkg::xLen'(4);

  always_comb begin
    // BTB miss means fall through
    predF = '{cls: bpredPkg::clsNone, taken: 1'b0, target: pcPlus4F};
    if (btbHit) begin
      predF.cls    = btbClass;
      predF.taken  = (btbClass == bpredPkg::clsBranch) ? dirTakenF
                                                       : (btbClass != bpredPkg::clsNone);
      predF.target = (btbClass == bpredPkg::clsReturn) ? rasTop : btbTarget;
    end
  end

  assign predPcF = predF.taken ? predF.target : pcPlus4F;

  ////////////////////
  // Execute check
  ////////////////////
  assign eValid     = validE && resolve.valid;
  assign pcCorrectE = resolve.taken ? resolve.target : pcE + bpredPkg::xLen'(4);

  // Compare against the instruction actually fetched next
  assign correct.wrong = eValid && decode.valid && (pcCorrectE != decode.pc);
  assign correct.pc    = pcCorrectE;
  assign pcNext        = correct.wrong ? pcCorrectE : predPcF;

  // Taken branch, jump or call, all BTB targets
  assign cfiE = (classE == bpredPkg::clsBranch) || (classE == bpredPkg::clsJump) ||
                (classE == bpredPkg::clsCall);

  // Direction only counts when the BTB also called it a branch
  assign missE.dirWrong    = eValid && (classE == bpredPkg::clsBranch) &&
                             (predE.cls == bpredPkg::clsBranch) && (predE.taken != resolve.taken);
  assign missE.targetWrong = eValid && cfiE && resolve.taken && (predE.target != resolve.target);
  assign missE.rasWrong    = eValid && (classE == bpredPkg::clsReturn) && resolve.taken &&
                             (predE.target != resolve.target);
  assign missE.classWrong  = eValid && (predE.cls != classE);

  // Table training
  assign updValid = eValid;
  assign updClass = classE;
  assign updPc    = pcE;

  // F to D to E prediction pipe, M miss register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      predD <= '0;
      predE <= '0;
      miss  <= '0;
    end else begin
      predD <= fetch.valid ? predF : '0;
      predE <= predD;
      miss  <= missE;
    end
  end

endmodule

// ==== rtl/bpred.sv ====
// Fetch-stage branch predictor, one instruction per cycle in lock step
// Caller supplies fetch, decode and resolved outcome each cycle
`timescale 1ns/100ps

module bpred (
  input  logic                       clk,
  input  logic                       rstN,
  input  bpredPkg::fetchT            fetch,
  input  bpredPkg::decodeT           decode,
  input  bpredPkg::resolveT          resolve,
  output logic [bpredPkg::xLen-1:0]  pcNext,
  output bpredPkg::correctT          correct,
  output bpredPkg::missT             miss
);

  bpredPkg::instrClassT       classE;
  logic [bpredPkg::xLen-1:0]  pcE;
  logic                       validE;
  logic                       dirTakenF;
  logic                       btbHit;
  bpredPkg::instrClassT       btbClass;
  logic [bpredPkg::xLen-1:0]  btbTarget;
  logic [bpredPkg::xLen-1:0]  rasTop;
  logic                       updValid;
  bpredPkg::instrClassT       updClass;
  logic [bpredPkg::xLen-1:0]  updPc;

  // Decode class is only consumed once it reaches execute
  instrClassDecode classDec_i (.clk, .rstN, .decode, .classD(), .classE, .pcE, .validE);

  twoBitPredictor dirPred_i (.clk, .rstN, .pcF(fetch.pc), .dirTakenF, .updValid, .updClass,
    .updPc, .taken(resolve.taken));

  btb btb_i (.clk, .rstN, .pcF(fetch.pc), .btbHit, .btbClass, .btbTarget, .updValid, .updClass,
    .updPc, .taken(resolve.taken), .target(resolve.target));

  returnStack ras_i (.clk, .rstN, .rasTop, .updValid, .updClass, .updPc);

  bpredResolve resolve_i (.clk, .rstN, .fetch, .decode, .resolve, .btbHit, .btbClass,
    .btbTarget, .dirTakenF, .rasTop, .classE, .pcE, .validE, .pcNext, .correct, .miss,
    .updValid, .updClass, .updPc);

endmodule

// ==== tb/bpredClock.sv ====
// Free-running 4 ns clock, reset low for the first 10 cycles
// Reset is released on a falling edge, away from the sampling edge
`timescale 1ns/100ps

module bpredClock (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rstN = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
  end

endmodule

// ==== tb/bpredMonitor.sv ====
// Compares DUT outputs with the reference values on each check request
// Miss reasons are compared one step after their execute step
`timescale 1ns/100ps

module bpredMonitor (
  input int                          checkReq,
  input int                          stepIdx,
  input logic [bpredPkg::xLen-1:0]   pcNext,
  input bpredPkg::correctT           correct,
  input bpredPkg::missT              miss,
  input logic [bpredPkg::xLen-1:0]   expPcNext,
  input bpredPkg::correctT           expCorrect,
  input bpredPkg::missT              expMiss
);

  int errCount = 0;
  int stepCount = 0;

  // Checks run a little after the falling edge, when all outputs are settled
  always @(checkReq) begin
    int bad;
    bad = 0;
    if (checkReq != 0) begin
      if (pcNext !== expPcNext) begin
        $display("Mismatch step %0d pcNext got %h expected %h", stepIdx, pcNext, expPcNext);
        bad++;
      end
      if (correct.wrong !== expCorrect.wrong) begin
        $display("Mismatch step %0d correct.wrong got %h expected %h", stepIdx,
          correct.wrong, expCorrect.wrong);
        bad++;
      end
      if (correct.pc !== expCorrect.pc) begin
        $display("Mismatch step %0d correct.pc got %h expected %h", stepIdx,
          correct.pc, expCorrect.pc);
        bad++;
      end
      // Miss reasons belong to the execute step one cycle earlier
      if (miss !== expMiss) begin
        $display("Mismatch step %0d miss got %h expected %h", stepIdx, miss, expMiss);
        bad++;
      end
      stepCount++;
      errCount += bad;
      if (bad == 0) $display("Step %0d ok", stepIdx);
      else $display("Step %0d failed with %0d wrong values", stepIdx, bad);
    end
  end

  task printSummary();
    $display("Steps checked %0d, errors %0d", stepCount, errCount);
  endtask

endmodule

// ==== tb/bpred_checker.sv ====
// Protocol properties of the predictor outputs, bound into every bpred
// Checked on the rising clock edge only
`timescale 1ns/100ps

module bpred_checker (
  input logic                        clk,
  input logic                        rstN,
  input bpredPkg::decodeT            decode,
  input bpredPkg::correctT           correct,
  input bpredPkg::missT              miss,
  input logic [bpredPkg::xLen-1:0]   pcNext
);

  // Nothing can have resolved yet right after reset
  missClearAfterReset: assert property (@(posedge clk) $rose(rstN) |-> (miss == '0))
    else $error("miss set in the first cycle after reset");

  // Needs a valid D now and a valid instruction that moved from D into E
  wrongNeedsDecode: assert property (@(posedge clk) disable iff (!rstN)
    correct.wrong |-> (decode.valid && $past(decode.valid)))
    else $error("correct.wrong raised without valid decode and execute stages");

  pcNextAligned: assert property (@(posedge clk) disable iff (!rstN) pcNext[1:0] == 2'b00)
    else $error("pcNext not word aligned");

endmodule

bind bpred bpred_checker chk_i (.clk, .rstN, .decode, .correct, .miss, .pcNext);

// ==== tb/bpredTb.sv ====
// Drives a program trace through F, D and E in lock step, one row per cycle
// Reference model keeps its own counters, BTB and RAS built from the predictor rules
`timescale 1ns/100ps

module bpredTb;

  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic        taken;
    logic [31:0] target;
  } rowT;

  // Encodings used by the trace
  localparam logic [31:0] nopI  = 32'h00000013;  // addi x0
  localparam logic [31:0] brI   = 32'h00000063;  // beq
  localparam logic [31:0] jmpI  = 32'h0000006f;  // jal x0
  localparam logic [31:0] callI = 32'h000000ef;  // jal x1
  localparam logic [31:0] retI  = 32'h00008067;  // jalr x0, 0(x1)

  logic clk;
  logic rstN;
  bpredPkg::fetchT            fetch;
  bpredPkg::decodeT           decode;
  bpredPkg::resolveT          resolve;
  logic [bpredPkg::xLen-1:0]  pcNext;
  bpredPkg::correctT          correct;
  bpredPkg::missT             miss;
  logic [bpredPkg::xLen-1:0]  expPcNext;
  bpredPkg::correctT          expCorrect;
  bpredPkg::missT             expMiss;
  int                         checkReq;
  int                         stepIdx;
  logic                       tableReady;
  rowT                        rows[$];

  ////////////////////
  // Reference model state
  ////////////////////
  logic [1:0]                 ctr [2**bpredPkg::dirIndexBits];
  logic                       btbV [2**bpredPkg::btbIndexBits];
  logic [31:0]                btbTag [2**bpredPkg::btbIndexBits];
  bpredPkg::instrClassT       btbCls [2**bpredPkg::btbIndexBits];
  logic [31:0]                btbTgt [2**bpredPkg::btbIndexBits];
  logic [31:0]                ras [bpredPkg::rasDepth];
  int                         rasPtr;
  bpredPkg::predictT          predF;
  bpredPkg::predictT          predD;
  bpredPkg::predictT          predE;
  bpredPkg::missT             missNext;
  bpredPkg::missT             missReg;
  bpredPkg::instrClassT       clsE;
  logic                       fValid;
  logic                       eValid;
  rowT                        eRow;

  bpredClock clkGen_i (.clk, .rstN);

  bpred dut_i (.clk, .rstN, .fetch, .decode, .resolve, .pcNext, .correct, .miss);

  bpredMonitor mon_i (.checkReq, .stepIdx, .pcNext, .correct, .miss, .expPcNext,
    .expCorrect, .expMiss);

  task automatic addRow(logic [31:0] pc, logic [31:0] instr, logic taken, logic [31:0] tgt);
    rows.push_back('{pc: pc, instr: instr, taken: taken, target: tgt});
  endtask

  task automatic buildTable();
    // Straight-line code, then a jump into the loop
    addRow(32'h000, nopI, 1'b0, 32'h0);
    addRow(32'h004, nopI, 1'b0, 32'h0);
    addRow(32'h008, jmpI, 1'b1, 32'h100);
    // First loop pass misses the BTB, fall-through fetched on the predicted path
    addRow(32'h100, nopI, 1'b0, 32'h0);
    addRow(32'h104, brI, 1'b1, 32'h100);
    addRow(32'h108, nopI, 1'b0, 32'h0);
    // Loop branch trains to strongly taken
    for (int i = 0; i < 4; i++) begin
      addRow(32'h100, nopI, 1'b0, 32'h0);
      addRow(32'h104, brI, 1'b1, 32'h100);
    end
    addRow(32'h100, nopI, 1'b0, 32'h0);
    addRow(32'h104, brI, 1'b0, 32'h0);
    // First call and return, both BTB misses
    // Callee body lets the push land before the return is fetched
    addRow(32'h108, callI, 1'b1, 32'h1f8);
    addRow(32'h1f8, nopI, 1'b0, 32'h0);
    addRow(32'h1fc, nopI, 1'b0, 32'h0);
    addRow(32'h200, retI, 1'b1, 32'h10c);
    addRow(32'h10c, jmpI, 1'b1, 32'h100);
    // Still predicted taken after one not-taken
    addRow(32'h100, nopI, 1'b0, 32'h0);
    addRow(32'h104, brI, 1'b1, 32'h100);
    addRow(32'h100, nopI, 1'b0, 32'h0);
    addRow(32'h104, brI, 1'b0, 32'h0);
    // Call and jump from the BTB, return from the RAS
    addRow(32'h108, callI, 1'b1, 32'h1f8);
    addRow(32'h1f8, nopI, 1'b0, 32'h0);
    addRow(32'h1fc, nopI, 1'b0, 32'h0);
    addRow(32'h200, retI, 1'b1, 32'h10c);
    addRow(32'h10c, jmpI, 1'b1, 32'h100);
    // Return to an address the RAS does not hold
    addRow(32'h200, retI, 1'b1, 32'h300);
    // Plain instruction where the BTB holds a branch
    addRow(32'h104, nopI, 1'b0, 32'h0);
    addRow(32'h100, nopI, 1'b0, 32'h0);
    addRow(32'h108, nopI, 1'b0, 32'h0);
  endtask

  function automatic bpredPkg::instrClassT classOf(logic [31:0] instr);
    logic rdLink;
    logic rs1Link;
    rdLink  = (instr[11:7] == 5'd1) || (instr[11:7] == 5'd5);
    rs1Link = (instr[19:15] == 5'd1) || (instr[19:15] == 5'd5);
    if (instr[6:0] == 7'b1100011) return bpredPkg::clsBranch;
    if (instr[6:0] == 7'b1101111) return rdLink ? bpredPkg::clsCall : bpredPkg::clsJump;
    if (instr[6:0] == 7'b1100111) begin
      return (rs1Link && (instr[11:7] == 5'd0)) ? bpredPkg::clsReturn : bpredPkg::clsJump;
    end
    return bpredPkg::clsNone;
  endfunction

  task automatic resetModel();
    foreach (ctr[i]) ctr[i] = 2'b01;
    foreach (btbV[i]) btbV[i] = 1'b0;
    foreach (ras[i]) ras[i] = '0;
    rasPtr  = 0;
    predD   = '0;
    predE   = '0;
    missReg = '0;
  endtask

  // Drives step k and works out what the DUT should show in this cycle
  task automatic applyStep(int k);
    rowT         f;
    rowT         d;
    logic        dValid;
    logic        hit;
    int          bi;
    logic [31:0] corr;
    logic        cfi;
    f = '0;
    d = '0;
    eRow = '0;
    fValid = k < rows.size();
    dValid = (k >= 1) && (k - 1 < rows.size());
    eValid = (k >= 2) && (k - 2 < rows.size());
    if (fValid) f = rows[k];
    if (dValid) d = rows[k-1];
    if (eValid) eRow = rows[k-2];
    fetch   = '{valid: fValid, pc: f.pc};
    decode  = '{valid: dValid, pc: d.pc, instr: d.instr};
    resolve = '{valid: eValid, taken: eRow.taken, target: eRow.target};
    // Fetch prediction from the model tables
    bi  = int'((f.pc >> 2) & 32'd15);
    hit = btbV[bi] && (btbTag[bi] == (f.pc >> 6));
    predF = '{cls: bpredPkg::clsNone, taken: 1'b0, target: f.pc + 4};
    if (hit) begin
      predF.cls    = btbCls[bi];
      predF.taken  = (btbCls[bi] == bpredPkg::clsBranch) ? ctr[int'((f.pc >> 2) & 32'd63)][1]
                                                         : 1'b1;
      predF.target = (btbCls[bi] == bpredPkg::clsReturn) ? ras[rasPtr] : btbTgt[bi];
    end
    // Execute check
    clsE = eValid ? classOf(eRow.instr) : bpredPkg::clsNone;
    corr = eRow.taken ? eRow.target : eRow.pc + 4;
    expCorrect.wrong = eValid && dValid && (corr != d.pc);
    expCorrect.pc    = corr;
    expPcNext = expCorrect.wrong ? corr : (predF.taken ? predF.target : f.pc + 4);
    expMiss   = missReg;
    cfi = (clsE == bpredPkg::clsBranch) || (clsE == bpredPkg::clsJump) ||
          (clsE == bpredPkg::clsCall);
    missNext.dirWrong    = eValid && (clsE == bpredPkg::clsBranch) &&
                           (predE.cls == bpredPkg::clsBranch) && (predE.taken != eRow.taken);
    missNext.targetWrong = eValid && cfi && eRow.taken && (predE.target != eRow.target);
    missNext.rasWrong    = eValid && (clsE == bpredPkg::clsReturn) && eRow.taken &&
                           (predE.target != eRow.target);
    missNext.classWrong  = eValid && (predE.cls != clsE);
  endtask

  // Table and pipe updates at the rising edge that ends the step
  task automatic commitStep();
    int di;
    int bi;
    di = int'((eRow.pc >> 2) & 32'd63);
    bi = int'((eRow.pc >> 2) & 32'd15);
    if (eValid) begin
      if (clsE == bpredPkg::clsBranch) begin
        if (eRow.taken && (ctr[di] != 2'b11)) ctr[di] = ctr[di] + 2'b01;
        else if (!eRow.taken && (ctr[di] != 2'b00)) ctr[di] = ctr[di] - 2'b01;
      end
      if (eRow.taken && (clsE != bpredPkg::clsNone)) begin
        btbV[bi]   = 1'b1;
        btbTag[bi] = eRow.pc >> 6;
        btbCls[bi] = clsE;
        btbTgt[bi] = eRow.target;
      end
      if (clsE == bpredPkg::clsCall) begin
        rasPtr      = (rasPtr + 1) % bpredPkg::rasDepth;
        ras[rasPtr] = eRow.pc + 4;
      end else if (clsE == bpredPkg::clsReturn) begin
        rasPtr = (rasPtr + bpredPkg::rasDepth - 1) % bpredPkg::rasDepth;
      end
    end
    predE   = predD;
    predD   = fValid ? predF : '0;
    missReg = missNext;
  endtask

  ////////////////////
  // Stimulus
  ////////////////////
  initial begin
    fetch      = '0;
    decode     = '0;
    resolve    = '0;
    checkReq   = 0;
    stepIdx    = 0;
    tableReady = 1'b0;
    buildTable();
    resetModel();
    tableReady = 1'b1;
    @(posedge rstN);
    // Three extra steps drain D, E and the miss register
    for (int k = 0; k < rows.size() + 3; k++) begin
      @(negedge clk);
      stepIdx = k;
      applyStep(k);
      #1;
      checkReq++;
      commitStep();
    end
    @(negedge clk);
    mon_i.printSummary();
    if (mon_i.errCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog sized from the trace length
  initial begin
    wait (tableReady);
    #((rows.size() + 20) * 4);
    $display("Watchdog timeout, the trace did not complete in time");
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== project.f ====
rtl/bpredPkg.sv
rtl/twoBitPredictor.sv
rtl/btb.sv
rtl/returnStack.sv
rtl/instrClassDecode.sv
rtl/bpredResolve.sv
rtl/bpred.sv
tb/bpredClock.sv
tb/bpredMonitor.sv
tb/bpred_checker.sv
tb/bpredTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the simulation log
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module bpredTb \
  --Mdir obj_dir -o simv > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "^Finished with no errors$" sim.log && echo "Run passed" ||
  { echo "Run failed, see build.log and sim.log"; exit 1; }
